// ==== wand_cfg.svh ====
`ifndef WAND_CFG_SVH
`define WAND_CFG_SVH

// Game timing
`define WAND_TICKS_PER_SEC 10 // Clock cycles per game second, short for simulation

// Scoring
`define WAND_TRACE_THRESHOLD 16'h8000 // Lowest IR reading inside the trace
`define WAND_POINTS_PER_TICK 3 // Added per in-trace second
`define WAND_SCORE_MAX 9999 // Keeps every score within four digits

// APB register map, byte offsets
`define WAND_REG_CTRL 8'h00 // bit0 start, bit1 two_player
`define WAND_REG_LEN 8'h04 // Game length in seconds
`define WAND_REG_STATUS 8'h08 // bit0 active, bit1 game_over
`define WAND_REG_TIME 8'h0C // Seconds left
`define WAND_REG_SCORE1 8'h10 // Player 1 binary score
`define WAND_REG_SCORE2 8'h14 // Player 2 binary score
`define WAND_REG_DIGITS1 8'h18 // Player 1 BCD digits
`define WAND_REG_DIGITS2 8'h1C // Player 2 BCD digits

// CTRL bit positions
`define WAND_CTRL_START 0
`define WAND_CTRL_TWO_PLAYER 1

`endif

// ==== wand_pkg.sv ====
`default_nettype none

package wand_pkg;

	// One player's score, never above 9999
	typedef logic [13:0] score_t;

	// Raw IR sensor sample
	typedef logic [15:0] ir_t;

	// Game length and countdown
	typedef logic [7:0] secs_t;

	// Four BCD digits, thousands in [15:12]
	typedef logic [15:0] bcd_t;

	// APB address and data
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Game countdown states
	typedef enum logic [1:0] {
		IDLE, // Waiting for the first start
		RUN, // Counting down
		DONE // Time is up, scores frozen
	} timer_state_t;

endpackage

`default_nettype wire

// ==== game_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface game_if import wand_pkg::*; ();
	logic tick; // One cycle per game second
	logic active; // Game running
	logic game_over; // Held until the next start
	secs_t seconds_left;
	logic start_pulse; // One cycle from the register block
	secs_t game_len;

	modport timer (output tick, active, game_over, seconds_left,
		input start_pulse, game_len);

	modport regs (output start_pulse, game_len,
		input tick, active, game_over, seconds_left);

	modport tracker (input tick, active);
endinterface

`default_nettype wire

// ==== screen_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wand_cfg.svh"

module screen_timer import wand_pkg::*; (
	input logic clock,
	input logic rst,
	game_if.timer gs // Game state out, start and length in
);

	localparam int TICK_W = $clog2(`WAND_TICKS_PER_SEC + 1);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`WAND_TICKS_PER_SEC - 1);

	timer_state_t state;
	logic [TICK_W-1:0] tick_cnt; // Cycles into the current second
	secs_t secs_q; // Countdown
	logic sec_done; // Last cycle of a second

	assign sec_done = (tick_cnt == TICK_LAST);
	assign gs.active = (state == RUN);
	assign gs.tick = gs.active && sec_done; // Only counts while running
	assign gs.game_over = (state == DONE); // Sticky until restart
	assign gs.seconds_left = secs_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
			tick_cnt <= '0;
			secs_q <= '0;
		end else if (gs.start_pulse) begin // Start or restart
			tick_cnt <= '0;
			secs_q <= gs.game_len;
			if (gs.game_len == '0) begin
				state <= DONE; // Zero length ends at once
			end else begin
				state <= RUN;
			end
		end else if (state == RUN) begin
			if (sec_done) begin
				tick_cnt <= '0;
				secs_q <= secs_q - 1'b1;
				if (secs_q == secs_t'(1)) begin
					state <= DONE; // Final tick still scores
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// A tick always has a second left to spend
	a_tick_in_game: assert property (@(posedge clock) disable iff (rst)
		gs.tick |-> secs_q != '0);

	// Countdown only moves down between starts
	a_no_wrap: assert property (@(posedge clock) disable iff (rst)
		!gs.start_pulse |=> secs_q <= $past(secs_q));

endmodule

`default_nettype wire

// ==== score_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wand_cfg.svh"

module score_tracker import wand_pkg::*; (
	input logic clock,
	input logic rst,
	game_if.tracker gs, // Tick and active from the timer
	input logic clear, // Start of a game
	input ir_t ir, // Raw sensor reading
	output score_t score
);

	localparam score_t SCORE_MAX = score_t'(`WAND_SCORE_MAX);

	ir_t ir_q; // Sampled reading
	logic in_trace;
	logic [$bits(score_t):0] sum; // One spare bit for the add
	score_t score_next;

	assign in_trace = (ir_q >= `WAND_TRACE_THRESHOLD);
	assign sum = {1'b0, score} + ($bits(score_t) + 1)'(`WAND_POINTS_PER_TICK);

	always_comb begin
		if (sum > {1'b0, SCORE_MAX}) begin
			score_next = SCORE_MAX; // Saturate
		end else begin
			score_next = sum[$bits(score_t)-1:0];
		end
	end

	always_ff @(posedge clock) begin
		ir_q <= ir; // Sensor input is asynchronous to game logic
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			score <= '0;
		end else if (clear) begin
			score <= '0; // New game
		end else if (gs.tick && gs.active && in_trace) begin
			score <= score_next;
		end
	end

	// Score never leaves four digits
	a_score_max: assert property (@(posedge clock) disable iff (rst)
		score <= SCORE_MAX);

	// Points land only on a game second or a start
	a_score_hold: assert property (@(posedge clock) disable iff (rst)
		!gs.tick && !clear |=> $stable(score));

endmodule

`default_nettype wire

// ==== score_to_digits.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_to_digits import wand_pkg::*; (
	input logic clock,
	input logic rst,
	input score_t score_a, // Player 1
	input score_t score_b, // Player 2
	output bcd_t digits_a,
	output bcd_t digits_b
);

	localparam int SW = $bits(score_t);
	localparam int BW = $bits(bcd_t);
	localparam logic [3:0] LAST = 4'(SW); // Step of the last shift

	logic [3:0] step; // 0 loads, 1..14 shift
	logic sel; // Player being converted
	score_t bin_q; // Binary bits still to shift in
	bcd_t bcd_q; // Partial digits
	bcd_t bcd_adj;
	logic [BW+SW-1:0] shifted;

	function automatic logic bcd_ok(bcd_t d);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (d[4*i +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// Add 3 to any digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int i = 0; i < 4; i++) begin
			if (bcd_q[4*i +: 4] >= 4'd5) begin
				bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
			end
		end
		shifted = {bcd_adj, bin_q} << 1;
	end

	always_ff @(posedge clock) begin
		if (step == '0) begin
			bin_q <= sel ? score_b : score_a; // Snapshot one score
			bcd_q <= '0;
		end else begin
			bin_q <= shifted[SW-1:0];
			bcd_q <= shifted[BW+SW-1:SW];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			step <= '0;
			sel <= 1'b0;
			digits_a <= '0;
			digits_b <= '0;
		end else if (step == LAST) begin
			step <= '0;
			sel <= ~sel; // Other player next
			if (sel) begin
				digits_b <= shifted[BW+SW-1:SW];
			end else begin
				digits_a <= shifted[BW+SW-1:SW];
			end
		end else begin
			step <= step + 1'b1;
		end
	end

	// Both outputs always hold valid BCD
	a_bcd_valid: assert property (@(posedge clock) disable iff (rst)
		bcd_ok(digits_a) && bcd_ok(digits_b));

endmodule

`default_nettype wire

// ==== game_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wand_cfg.svh"

module game_regs import wand_pkg::*; (
	input logic clock,
	input logic rst,
	input apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	game_if.regs gs, // Start and length out, game state in
	input score_t score1,
	input score_t score2,
	input bcd_t digits1,
	input bcd_t digits2,
	output logic two_player // Gates player 2 at the top
);

	logic setup; // First APB phase
	logic access; // Access phase, repeats while pready low
	logic done; // Transfer completes this cycle
	logic mapped;
	apb_data_t rd_data;
	logic start_q;
	secs_t len_q;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign done = access && pready;
	assign gs.start_pulse = start_q;
	assign gs.game_len = len_q;

	// Read mux and address decode
	always_comb begin
		rd_data = '0;
		mapped = 1'b1;
		case (paddr)
			`WAND_REG_CTRL: rd_data[`WAND_CTRL_TWO_PLAYER] = two_player; // Start reads 0
			`WAND_REG_LEN: rd_data = apb_data_t'(len_q);
			`WAND_REG_STATUS: rd_data = {30'd0, gs.game_over, gs.active};
			`WAND_REG_TIME: rd_data = apb_data_t'(gs.seconds_left);
			`WAND_REG_SCORE1: rd_data = apb_data_t'(score1);
			`WAND_REG_SCORE2: rd_data = apb_data_t'(score2);
			`WAND_REG_DIGITS1: rd_data = apb_data_t'(digits1);
			`WAND_REG_DIGITS2: rd_data = apb_data_t'(digits2);
			default: mapped = 1'b0; // Error response
		endcase
	end

	// Handshake, writes ready in the first access, reads in the second
	always_ff @(posedge clock) begin
		if (rst) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			prdata <= '0;
		end else if (done) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else if (setup && pwrite) begin
			pready <= 1'b1;
			pslverr <= !mapped;
		end else if (access && !pwrite) begin // Read wait state
			pready <= 1'b1;
			pslverr <= !mapped;
			prdata <= rd_data;
		end
	end

	// Control registers, updated on the completing write
	always_ff @(posedge clock) begin
		if (rst) begin
			start_q <= 1'b0;
			two_player <= 1'b0;
			len_q <= '0;
		end else begin
			start_q <= 1'b0; // Self-clearing
			if (done && pwrite) begin
				case (paddr)
					`WAND_REG_CTRL: begin
						start_q <= pwdata[`WAND_CTRL_START];
						two_player <= pwdata[`WAND_CTRL_TWO_PLAYER];
					end
					`WAND_REG_LEN: len_q <= pwdata[$bits(secs_t)-1:0];
					default: ; // Read-only or unmapped
				endcase
			end
		end
	end

	// Ready only inside a transfer the master has opened
	a_ready_in_access: assert property (@(posedge clock) disable iff (rst)
		$rose(pready) |-> psel && penable);

	// Read data moves only as a read completes
	a_rdata_stable: assert property (@(posedge clock) disable iff (rst)
		$changed(prdata) |-> $rose(pready) && !pwrite);

endmodule

`default_nettype wire

// ==== wand_game.sv ====
`timescale 1ns/1ps
`default_nettype none

module wand_game import wand_pkg::*; (
	input logic clock,
	input logic rst,
	input apb_addr_t paddr, // APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input ir_t ir_p1, // IR readings
	input ir_t ir_p2
);

	score_t score1, score2;
	bcd_t digits1, digits2;
	logic two_player;
	ir_t ir_p2_gated; // Zero is outside the trace

	assign ir_p2_gated = two_player ? ir_p2 : '0;

	game_if gs ();

	screen_timer u_timer (.clock(clock), .rst(rst), .gs(gs.timer));

	score_tracker u_track1 (.clock(clock), .rst(rst), .gs(gs.tracker),
		.clear(gs.start_pulse), .ir(ir_p1), .score(score1));

	score_tracker u_track2 (.clock(clock), .rst(rst), .gs(gs.tracker),
		.clear(gs.start_pulse), .ir(ir_p2_gated), .score(score2));

	score_to_digits u_digits (.clock(clock), .rst(rst),
		.score_a(score1), .score_b(score2),
		.digits_a(digits1), .digits_b(digits2));

	game_regs u_regs (
		.clock(clock),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.gs(gs.regs),
		.score1(score1),
		.score2(score2),
		.digits1(digits1),
		.digits2(digits2),
		.two_player(two_player)
	);

endmodule

`default_nettype wire

// ==== tb_wand_game.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wand_cfg.svh"

module tb_wand_game import wand_pkg::*; ();

	localparam int APB_TIMEOUT = 20; // Cycles allowed for pready
	localparam int GAME_POLLS = 2000; // STATUS reads allowed per game

	logic clock;
	logic rst;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	ir_t ir_p1;
	ir_t ir_p2;

	int errors; // Failed checks so far
	int tests_run;
	int test_start_errors; // Errors at test entry
	logic [31:0] rng_state;
	logic last_slverr; // Error flag of the last transfer
	logic hung; // A wait ran out of time

	wand_game DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock; // 100 ns period
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Reference conversion one digit at a time
	function automatic bcd_t to_bcd(int value);
		bcd_t d;
		d[15:12] = 4'(value / 1000);
		d[11:8] = 4'((value / 100) % 10);
		d[7:4] = 4'((value / 10) % 10);
		d[3:0] = 4'(value % 10);
		return d;
	endfunction

	function automatic score_t expected_score(int len);
		int s;
		s = len * `WAND_POINTS_PER_TICK;
		if (s > `WAND_SCORE_MAX) begin
			s = `WAND_SCORE_MAX; // Saturation
		end
		return score_t'(s);
	endfunction

	task automatic fail_timeout(string what);
		$display("Timeout: %s never completed", what);
		hung = 1'b1; // Watchdog ends the run
	endtask

	// Stops the run as soon as a wait gives up
	initial begin
		wait (hung);
		$display("Something failed");
		$finish;
	end

	task automatic check_score(string name, score_t exp, score_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bcd(string name, bcd_t exp, bcd_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_secs(string name, secs_t exp, secs_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_data(string name, apb_data_t exp, apb_data_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic apb_write(apb_addr_t addr, apb_data_t data);
		int n;
		@(posedge clock);
		paddr <= addr; // Setup phase
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clock);
		penable <= 1'b1;
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > APB_TIMEOUT) fail_timeout("APB write");
		end while (!pready);
		last_slverr = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(apb_addr_t addr, output apb_data_t data);
		int n;
		@(posedge clock);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clock);
		penable <= 1'b1;
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > APB_TIMEOUT) fail_timeout("APB read");
		end while (!pready);
		data = prdata; // Sampled while pready high
		last_slverr = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_game_over();
		apb_data_t st;
		int n;
		n = 0;
		do begin
			apb_read(`WAND_REG_STATUS, st);
			n++;
			if (n > GAME_POLLS) fail_timeout("game over wait");
		end while (!st[1]);
	endtask

	task automatic begin_test();
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic end_test(string name);
		$display("%s: %s", name, (errors == test_start_errors) ? "pass" : "FAIL");
	endtask

	// Both sets the IR lines and starts a game of the given length
	task automatic start_game(secs_t len, logic two, ir_t r1, ir_t r2);
		@(posedge clock);
		ir_p1 <= r1;
		ir_p2 <= r2;
		apb_write(`WAND_REG_LEN, apb_data_t'(len));
		apb_write(`WAND_REG_CTRL, {30'd0, two, 1'b1});
	endtask

	task automatic test_reset_values();
		apb_data_t d;
		begin_test();
		for (int a = 0; a < 8; a++) begin
			apb_read(apb_addr_t'(a * 4), d);
			check_data("reset_values", 32'd0, d);
		end
		apb_read(8'h40, d); // Unmapped
		if (!last_slverr) begin
			$display("reset_values: unmapped read completed without pslverr");
			errors++;
		end
		end_test("reset_values");
	endtask

	task automatic test_config_start();
		apb_data_t d;
		begin_test();
		apb_write(`WAND_REG_LEN, 32'd20);
		apb_write(`WAND_REG_CTRL, 32'h2); // two_player only
		apb_read(`WAND_REG_LEN, d);
		check_data("config_len", 32'd20, d);
		apb_read(`WAND_REG_CTRL, d);
		check_data("config_ctrl", 32'h2, d);
		apb_write(`WAND_REG_CTRL, 32'h3);
		apb_read(`WAND_REG_TIME, d);
		if (d > 32'd20 || d == 32'd0) begin
			$display("** Error config_time: expected 1..20, actual %0d", d);
			errors++;
		end
		apb_read(`WAND_REG_STATUS, d);
		check_data("config_status", 32'h1, d);
		wait_game_over();
		end_test("config_start");
	endtask

	task automatic test_full_trace();
		apb_data_t d;
		secs_t len;
		begin_test();
		len = secs_t'(xorshift() % 40 + 1);
		start_game(len, 1'b1, 16'h8000 | 16'(xorshift()), 16'h8000 | 16'(xorshift()));
		wait_game_over();
		apb_read(`WAND_REG_SCORE1, d);
		check_score("full_trace_p1", expected_score(len), score_t'(d));
		apb_read(`WAND_REG_SCORE2, d);
		check_score("full_trace_p2", expected_score(len), score_t'(d));
		apb_read(`WAND_REG_STATUS, d);
		check_data("full_trace_status", 32'h2, d);
		apb_read(`WAND_REG_TIME, d);
		check_secs("full_trace_time", 8'd0, secs_t'(d));
		end_test("full_trace");
	endtask

	task automatic test_gating_long();
		apb_data_t d;
		begin_test();
		start_game(8'd12, 1'b0, 16'h7fff & 16'(xorshift()), 16'h8000 | 16'(xorshift()));
		wait_game_over();
		apb_read(`WAND_REG_SCORE1, d);
		check_score("gating_p1", 14'd0, score_t'(d));
		apb_read(`WAND_REG_SCORE2, d);
		check_score("gating_p2", 14'd0, score_t'(d));
		start_game(8'd255, 1'b1, 16'hffff, 16'h8000); // Longest game
		wait_game_over();
		apb_read(`WAND_REG_SCORE1, d);
		check_score("long_p1", expected_score(255), score_t'(d));
		apb_read(`WAND_REG_SCORE2, d);
		check_score("long_p2", expected_score(255), score_t'(d));
		end_test("gating_long");
	endtask

	task automatic test_digits();
		apb_data_t d;
		secs_t len;
		begin_test();
		len = secs_t'(xorshift() % 40 + 1);
		start_game(len, 1'b1, 16'hc000, 16'h7000); // Player 2 outside
		wait_game_over();
		repeat (40) @(posedge clock); // Converter catches up
		apb_read(`WAND_REG_DIGITS1, d);
		check_bcd("digits_p1", to_bcd(expected_score(len)), bcd_t'(d));
		apb_read(`WAND_REG_DIGITS2, d);
		check_bcd("digits_p2", to_bcd(0), bcd_t'(d));
		end_test("digits");
	endtask

	task automatic test_restart();
		apb_data_t d;
		begin_test();
		start_game(8'd30, 1'b1, 16'h9000, 16'ha000);
		repeat (45) @(posedge clock); // A few seconds in
		apb_write(`WAND_REG_LEN, 32'd5);
		apb_write(`WAND_REG_CTRL, 32'h3); // Restart
		apb_read(`WAND_REG_SCORE1, d);
		check_score("restart_clear", 14'd0, score_t'(d));
		wait_game_over();
		apb_read(`WAND_REG_SCORE1, d);
		check_score("restart_p1", expected_score(5), score_t'(d));
		apb_read(`WAND_REG_SCORE2, d);
		check_score("restart_p2", expected_score(5), score_t'(d));
		end_test("restart");
	endtask

	initial begin
		errors = 0;
		tests_run = 0;
		hung = 1'b0;
		rng_state = 32'h09d6_9d78;
		rst <= 1'b1;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		ir_p1 <= '0;
		ir_p2 <= '0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		test_reset_values();
		test_config_start();
		test_full_trace();
		test_gating_long();
		test_digits();
		test_restart();
		$display("Tests: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
wand_pkg.sv
game_if.sv
screen_timer.sv
score_tracker.sv
score_to_digits.sv
game_regs.sv
wand_game.sv
tb_wand_game.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_wand_game
FILELIST  ?= vlog.f
PASS_MSG  := Everything OK

SRCS := $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: $(BIN)
	./$(BIN) | grep "$(PASS_MSG)"

clean:
	rm -rf obj_dir
